// ==== Makefile ====
SRCS := $(wildcard src/*.sv verification/*.sv)

obj_dir/Vint_pipeline_tb: build.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module int_pipeline_tb -f build.f

run: obj_dir/Vint_pipeline_tb
	@out="$$(./obj_dir/Vint_pipeline_tb +verilator+error+limit+100)"; echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== build.f ====
src/core_pkg.sv
src/inst_decoder.sv
src/reg_file.sv
src/data_select_stage.sv
src/exec_stage.sv
src/retire_pipe.sv
src/int_pipeline.sv
verification/int_pipeline_assertions.sv
verification/int_pipeline_tb.sv

// ==== src/core_pkg.sv ====
package core_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // one instruction word, read through the view its opcode calls for
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } r;
        struct packed {
            logic [11:0]           imm12;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } i;
        struct packed {
            logic [19:0]           imm20;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } u;
    } inst_word;

    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;

    localparam logic [1:0] op1_rs1  = 2'd0;
    localparam logic [1:0] op1_pc   = 2'd1;
    localparam logic [1:0] op1_zero = 2'd2;

    localparam logic [1:0] op2_rs2 = 2'd0;
    localparam logic [1:0] op2_imi = 2'd1;
    localparam logic [1:0] op2_imu = 2'd2;

    localparam logic [3:0] alu_add  = 4'd0;
    localparam logic [3:0] alu_sub  = 4'd1;
    localparam logic [3:0] alu_and  = 4'd2;
    localparam logic [3:0] alu_or   = 4'd3;
    localparam logic [3:0] alu_xor  = 4'd4;
    localparam logic [3:0] alu_slt  = 4'd5;
    localparam logic [3:0] alu_sltu = 4'd6;
    localparam logic [3:0] alu_sll  = 4'd7;
    localparam logic [3:0] alu_srl  = 4'd8;
    localparam logic [3:0] alu_sra  = 4'd9;

endpackage

// ==== src/data_select_stage.sv ====
module data_select_stage (
    input  logic                            clk,
    input  logic                            ds_valid,
    input  logic [core_pkg::xlen-1:0]       pc,
    input  logic [core_pkg::xlen-1:0]       inst,
    input  logic [core_pkg::reg_addr_w-1:0] rs1_addr,
    input  logic [core_pkg::reg_addr_w-1:0] rs2_addr,
    input  logic [core_pkg::xlen-1:0]       rs1_rf,
    input  logic [core_pkg::xlen-1:0]       rs2_rf,
    input  logic [1:0]                      op1_sel,
    input  logic [1:0]                      op2_sel,
    input  logic [3:0]                      alu_fn,
    input  logic                            rf_wen,
    input  logic [core_pkg::reg_addr_w-1:0] wb_addr,
    input  logic                            illegal,
    input  logic [core_pkg::xlen-1:0]       imm_i,
    input  logic [core_pkg::xlen-1:0]       imm_u,
    input  logic                            exe_fw_valid,
    input  logic                            exe_fw_can_forward,
    input  logic [core_pkg::reg_addr_w-1:0] exe_fw_addr,
    input  logic [core_pkg::xlen-1:0]       exe_fw_wdata,
    input  logic                            mem_fw_valid,
    input  logic                            mem_fw_can_forward,
    input  logic [core_pkg::reg_addr_w-1:0] mem_fw_addr,
    input  logic [core_pkg::xlen-1:0]       mem_fw_wdata,
    input  logic                            wb_fw_valid,
    input  logic                            wb_fw_can_forward,
    input  logic [core_pkg::reg_addr_w-1:0] wb_fw_addr,
    input  logic [core_pkg::xlen-1:0]       wb_fw_wdata,
    output logic                            stall,
    output logic                            ds_exe_valid,
    output logic [core_pkg::xlen-1:0]       ds_exe_pc,
    output logic [core_pkg::xlen-1:0]       ds_exe_inst,
    output logic [core_pkg::xlen-1:0]       ds_exe_op1_data,
    output logic [core_pkg::xlen-1:0]       ds_exe_op2_data,
    output logic [3:0]                      ds_exe_alu_fn,
    output logic                            ds_exe_rf_wen,
    output logic [core_pkg::reg_addr_w-1:0] ds_exe_wb_addr
);

    logic                      exe_rs1, exe_rs2, mem_rs1, mem_rs2, wb_rs1, wb_rs2;
    logic [core_pkg::xlen-1:0] rs1_data, rs2_data;

    // per-stage source matches
    assign exe_rs1 = exe_fw_valid && exe_fw_addr == rs1_addr && rs1_addr != '0;
    assign exe_rs2 = exe_fw_valid && exe_fw_addr == rs2_addr && rs2_addr != '0;
    assign mem_rs1 = mem_fw_valid && mem_fw_addr == rs1_addr && rs1_addr != '0;
    assign mem_rs2 = mem_fw_valid && mem_fw_addr == rs2_addr && rs2_addr != '0;
    assign wb_rs1  = wb_fw_valid && wb_fw_addr == rs1_addr && rs1_addr != '0;
    assign wb_rs2  = wb_fw_valid && wb_fw_addr == rs2_addr && rs2_addr != '0;

    assign stall = ds_valid && (
        (!exe_fw_can_forward && (exe_rs1 || exe_rs2)) ||
        (!mem_fw_can_forward && (mem_rs1 || mem_rs2)) ||
        (!wb_fw_can_forward && (wb_rs1 || wb_rs2)));

    // youngest forwarding stage wins, exe never can in this core
    assign rs1_data = rs1_addr == '0 ? '0 :
                      exe_rs1 && exe_fw_can_forward ? exe_fw_wdata :
                      mem_rs1 && mem_fw_can_forward ? mem_fw_wdata :
                      wb_rs1 && wb_fw_can_forward ? wb_fw_wdata : rs1_rf;
    assign rs2_data = rs2_addr == '0 ? '0 :
                      exe_rs2 && exe_fw_can_forward ? exe_fw_wdata :
                      mem_rs2 && mem_fw_can_forward ? mem_fw_wdata :
                      wb_rs2 && wb_fw_can_forward ? wb_fw_wdata : rs2_rf;

    always_comb begin
        case (op1_sel)
            core_pkg::op1_rs1: ds_exe_op1_data = rs1_data;
            core_pkg::op1_pc:  ds_exe_op1_data = pc;
            default:           ds_exe_op1_data = '0;
        endcase
        case (op2_sel)
            core_pkg::op2_rs2: ds_exe_op2_data = rs2_data;
            core_pkg::op2_imi: ds_exe_op2_data = imm_i;
            core_pkg::op2_imu: ds_exe_op2_data = imm_u;
            default:           ds_exe_op2_data = '0;
        endcase
    end

    // illegal words are taken but go on as bubbles
    assign ds_exe_valid   = ds_valid && !stall && !illegal;
    assign ds_exe_pc      = pc;
    assign ds_exe_inst    = inst;
    assign ds_exe_alu_fn  = alu_fn;
    assign ds_exe_rf_wen  = rf_wen;
    assign ds_exe_wb_addr = wb_addr;

endmodule

// ==== src/exec_stage.sv ====
module exec_stage (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            ds_exe_valid,
    input  logic [core_pkg::xlen-1:0]       ds_exe_pc,
    input  logic [core_pkg::xlen-1:0]       ds_exe_inst,
    input  logic [core_pkg::xlen-1:0]       ds_exe_op1_data,
    input  logic [core_pkg::xlen-1:0]       ds_exe_op2_data,
    input  logic [3:0]                      ds_exe_alu_fn,
    input  logic                            ds_exe_rf_wen,
    input  logic [core_pkg::reg_addr_w-1:0] ds_exe_wb_addr,
    output logic                            fw_valid,
    output logic                            fw_can_forward,
    output logic [core_pkg::reg_addr_w-1:0] fw_addr,
    output logic [core_pkg::xlen-1:0]       fw_wdata,
    output logic                            ex_valid,
    output logic [core_pkg::xlen-1:0]       ex_result,
    output logic                            ex_rf_wen,
    output logic [core_pkg::reg_addr_w-1:0] ex_wb_addr,
    output logic [core_pkg::xlen-1:0]       ex_pc,
    output logic [core_pkg::xlen-1:0]       ex_inst
);

    logic [core_pkg::xlen-1:0] op1, op2;
    logic [3:0]                fn;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= ds_exe_valid;
        end
    end

    always_ff @(posedge clk) begin
        op1        <= ds_exe_op1_data;
        op2        <= ds_exe_op2_data;
        fn         <= ds_exe_alu_fn;
        ex_rf_wen  <= ds_exe_rf_wen;
        ex_wb_addr <= ds_exe_wb_addr;
        ex_pc      <= ds_exe_pc;
        ex_inst    <= ds_exe_inst;
    end

    always_comb begin
        case (fn)
            core_pkg::alu_sub:  ex_result = op1 - op2;
            core_pkg::alu_and:  ex_result = op1 & op2;
            core_pkg::alu_or:   ex_result = op1 | op2;
            core_pkg::alu_xor:  ex_result = op1 ^ op2;
            core_pkg::alu_slt:  ex_result = {31'b0, $signed(op1) < $signed(op2)};
            core_pkg::alu_sltu: ex_result = {31'b0, op1 < op2};
            core_pkg::alu_sll:  ex_result = op1 << op2[4:0];
            core_pkg::alu_srl:  ex_result = op1 >> op2[4:0];
            core_pkg::alu_sra:  ex_result = $signed(op1) >>> op2[4:0];
            default:            ex_result = op1 + op2;
        endcase
    end

    // result is not ready in time to forward from here
    assign fw_valid       = ex_valid && ex_rf_wen;
    assign fw_can_forward = 1'b0;
    assign fw_addr        = ex_wb_addr;
    assign fw_wdata       = ex_result;

endmodule

// ==== src/inst_decoder.sv ====
module inst_decoder (
    input  logic [core_pkg::xlen-1:0]       inst,
    output logic [core_pkg::reg_addr_w-1:0] rs1_addr,
    output logic [core_pkg::reg_addr_w-1:0] rs2_addr,
    output logic [core_pkg::reg_addr_w-1:0] wb_addr,
    output logic [1:0]                      op1_sel,
    output logic [1:0]                      op2_sel,
    output logic [3:0]                      alu_fn,
    output logic                            rf_wen,
    output logic                            illegal,
    output logic [core_pkg::xlen-1:0]       imm_i,
    output logic [core_pkg::xlen-1:0]       imm_u
);

    core_pkg::inst_word iw;

    // funct3 to alu code, alt picks sub or sra
    function automatic logic [3:0] alu_code(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  alu_code = alt ? core_pkg::alu_sub : core_pkg::alu_add;
            3'b001:  alu_code = core_pkg::alu_sll;
            3'b010:  alu_code = core_pkg::alu_slt;
            3'b011:  alu_code = core_pkg::alu_sltu;
            3'b100:  alu_code = core_pkg::alu_xor;
            3'b101:  alu_code = alt ? core_pkg::alu_sra : core_pkg::alu_srl;
            3'b110:  alu_code = core_pkg::alu_or;
            default: alu_code = core_pkg::alu_and;
        endcase
    endfunction

    assign iw      = inst;
    assign wb_addr = iw.u.rd;
    assign imm_i   = {{20{iw.i.imm12[11]}}, iw.i.imm12};
    assign imm_u   = {iw.u.imm20, 12'b0};
    assign rf_wen  = !illegal && iw.u.rd != '0;

    // unused source fields stay at x0 so they never match a hazard
    always_comb begin
        rs1_addr = '0;
        rs2_addr = '0;
        op1_sel  = core_pkg::op1_zero;
        op2_sel  = core_pkg::op2_imu;
        alu_fn   = core_pkg::alu_add;
        illegal  = 1'b0;
        case (iw.u.opcode)
            core_pkg::opc_op: begin
                rs1_addr = iw.r.rs1;
                rs2_addr = iw.r.rs2;
                op1_sel  = core_pkg::op1_rs1;
                op2_sel  = core_pkg::op2_rs2;
                alu_fn   = alu_code(iw.r.funct3, iw.r.funct7[5]);
                if (iw.r.funct7 == 7'h20) begin
                    illegal = iw.r.funct3 != 3'b000 && iw.r.funct3 != 3'b101;
                end else begin
                    illegal = iw.r.funct7 != 7'h00;
                end
            end
            core_pkg::opc_op_imm: begin
                rs1_addr = iw.i.rs1;
                op1_sel  = core_pkg::op1_rs1;
                op2_sel  = core_pkg::op2_imi;
                // bit 30 only selects sra for shifts, shamt is imm12[4:0]
                alu_fn   = alu_code(iw.i.funct3, iw.i.funct3 == 3'b101 && iw.i.imm12[10]);
                if (iw.i.funct3 == 3'b001) begin
                    illegal = iw.i.imm12[11:5] != 7'h00;
                end else if (iw.i.funct3 == 3'b101) begin
                    illegal = iw.i.imm12[11:5] != 7'h00 && iw.i.imm12[11:5] != 7'h20;
                end
            end
            core_pkg::opc_lui: begin
                op1_sel = core_pkg::op1_zero;
            end
            core_pkg::opc_auipc: begin
                op1_sel = core_pkg::op1_pc;
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

// ==== src/int_pipeline.sv ====
module int_pipeline (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            inst_valid,
    input  logic [core_pkg::xlen-1:0]       inst,
    input  logic [core_pkg::xlen-1:0]       pc,
    output logic                            stall,
    output logic                            retire_valid,
    output logic [core_pkg::xlen-1:0]       retire_pc,
    output logic [core_pkg::xlen-1:0]       retire_inst,
    output logic                            retire_wen,
    output logic [core_pkg::reg_addr_w-1:0] retire_addr,
    output logic [core_pkg::xlen-1:0]       retire_data
);

    logic [core_pkg::reg_addr_w-1:0] rs1_addr, rs2_addr, wb_addr, ds_exe_wb_addr, ex_wb_addr;
    logic [core_pkg::reg_addr_w-1:0] exe_fw_addr, mem_fw_addr, wb_fw_addr, rf_waddr;
    logic [1:0]                      op1_sel, op2_sel;
    logic [3:0]                      alu_fn, ds_exe_alu_fn;
    logic                            rf_wen, illegal, ds_exe_valid, ds_exe_rf_wen;
    logic                            ex_valid, ex_rf_wen, rf_we;
    logic                            exe_fw_valid, exe_fw_can_forward, mem_fw_valid;
    logic                            mem_fw_can_forward, wb_fw_valid, wb_fw_can_forward;
    logic [core_pkg::xlen-1:0]       imm_i, imm_u, rs1_rf, rs2_rf, ds_exe_pc, ds_exe_inst;
    logic [core_pkg::xlen-1:0]       ds_exe_op1_data, ds_exe_op2_data, ex_result, ex_pc, ex_inst;
    logic [core_pkg::xlen-1:0]       exe_fw_wdata, mem_fw_wdata, wb_fw_wdata, rf_wdata;

    inst_decoder inst_decoder_inst (.*);

    reg_file reg_file_inst (
        .clk, .rst, .raddr1(rs1_addr), .raddr2(rs2_addr), .rdata1(rs1_rf), .rdata2(rs2_rf),
        .wen(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
    );

    data_select_stage data_select_stage_inst (.*, .ds_valid(inst_valid));

    exec_stage exec_stage_inst (
        .*, .fw_valid(exe_fw_valid), .fw_can_forward(exe_fw_can_forward),
        .fw_addr(exe_fw_addr), .fw_wdata(exe_fw_wdata)
    );

    retire_pipe retire_pipe_inst (.*, .rf_wen(rf_we));

endmodule

// ==== src/reg_file.sv ====
module reg_file (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [core_pkg::reg_addr_w-1:0] raddr1,
    input  logic [core_pkg::reg_addr_w-1:0] raddr2,
    output logic [core_pkg::xlen-1:0]       rdata1,
    output logic [core_pkg::xlen-1:0]       rdata2,
    input  logic                            wen,
    input  logic [core_pkg::reg_addr_w-1:0] waddr,
    input  logic [core_pkg::xlen-1:0]       wdata
);

    logic [core_pkg::xlen-1:0] regs [2**core_pkg::reg_addr_w];

    // x0 is cleared by reset and never written, so it reads zero
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**core_pkg::reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

// ==== src/retire_pipe.sv ====
module retire_pipe (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            ex_valid,
    input  logic [core_pkg::xlen-1:0]       ex_result,
    input  logic                            ex_rf_wen,
    input  logic [core_pkg::reg_addr_w-1:0] ex_wb_addr,
    input  logic [core_pkg::xlen-1:0]       ex_pc,
    input  logic [core_pkg::xlen-1:0]       ex_inst,
    output logic                            mem_fw_valid,
    output logic                            mem_fw_can_forward,
    output logic [core_pkg::reg_addr_w-1:0] mem_fw_addr,
    output logic [core_pkg::xlen-1:0]       mem_fw_wdata,
    output logic                            wb_fw_valid,
    output logic                            wb_fw_can_forward,
    output logic [core_pkg::reg_addr_w-1:0] wb_fw_addr,
    output logic [core_pkg::xlen-1:0]       wb_fw_wdata,
    output logic                            rf_wen,
    output logic [core_pkg::reg_addr_w-1:0] rf_waddr,
    output logic [core_pkg::xlen-1:0]       rf_wdata,
    output logic                            retire_valid,
    output logic [core_pkg::xlen-1:0]       retire_pc,
    output logic [core_pkg::xlen-1:0]       retire_inst,
    output logic                            retire_wen,
    output logic [core_pkg::reg_addr_w-1:0] retire_addr,
    output logic [core_pkg::xlen-1:0]       retire_data
);

    logic                            mem_valid, mem_wen, wb_valid, wb_wen;
    logic [core_pkg::reg_addr_w-1:0] mem_addr, wb_addr;
    logic [core_pkg::xlen-1:0]       mem_result, mem_pc, mem_inst, wb_result, wb_pc, wb_inst;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_valid <= 1'b0;
            wb_valid  <= 1'b0;
        end else begin
            mem_valid <= ex_valid;
            wb_valid  <= mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        mem_wen    <= ex_rf_wen;
        mem_addr   <= ex_wb_addr;
        mem_result <= ex_result;
        mem_pc     <= ex_pc;
        mem_inst   <= ex_inst;
        wb_wen     <= mem_wen;
        wb_addr    <= mem_addr;
        wb_result  <= mem_result;
        wb_pc      <= mem_pc;
        wb_inst    <= mem_inst;
    end

    assign mem_fw_valid       = mem_valid && mem_wen;
    assign mem_fw_can_forward = 1'b1;
    assign mem_fw_addr        = mem_addr;
    assign mem_fw_wdata       = mem_result;
    assign wb_fw_valid        = wb_valid && wb_wen;
    assign wb_fw_can_forward  = 1'b1;
    assign wb_fw_addr         = wb_addr;
    assign wb_fw_wdata        = wb_result;

    // wb register drives both the write port and the retire view
    assign rf_wen       = wb_valid && wb_wen;
    assign rf_waddr     = wb_addr;
    assign rf_wdata     = wb_result;
    assign retire_valid = wb_valid;
    assign retire_pc    = wb_pc;
    assign retire_inst  = wb_inst;
    assign retire_wen   = rf_wen;
    assign retire_addr  = wb_addr;
    assign retire_data  = wb_result;

endmodule

// ==== verification/int_pipeline_assertions.sv ====
module int_pipeline_assertions (
    input logic                            clk,
    input logic                            rst,
    input logic                            inst_valid,
    input logic [core_pkg::xlen-1:0]       inst,
    input logic [core_pkg::xlen-1:0]       pc,
    input logic                            stall,
    input logic                            retire_valid,
    input logic [core_pkg::xlen-1:0]       retire_pc,
    input logic [core_pkg::xlen-1:0]       retire_inst,
    input logic                            retire_wen,
    input logic [core_pkg::reg_addr_w-1:0] retire_addr,
    input logic [core_pkg::xlen-1:0]       retire_data
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0]        model [32];
    logic [31:0]        pc_q [3];
    logic [31:0]        inst_q [3];
    logic [2:0]         acc_q;
    logic [31:0]        expect_data;
    logic               exe_hazard;
    core_pkg::inst_word ret_w;
    int                 errors = 0;

    function automatic logic kept(input core_pkg::inst_word w);
        return w.r.opcode inside {core_pkg::opc_op, core_pkg::opc_op_imm,
                                  core_pkg::opc_lui, core_pkg::opc_auipc};
    endfunction

    // RV32I result from operand values
    function automatic logic [31:0] golden(input core_pkg::inst_word w, input logic [31:0] a,
                                           input logic [31:0] b, input logic [31:0] p);
        logic        [31:0] y;
        logic signed [31:0] sa;
        sa = a;
        y = w.r.opcode == core_pkg::opc_op ? b : {{20{w.i.imm12[11]}}, w.i.imm12};
        case (w.r.funct3)
            3'd0: golden = w.r.opcode == core_pkg::opc_op && w.r.funct7[5] ? a - y : a + y;
            3'd1: golden = a << y[4:0];
            3'd2: golden = {31'b0, sa < $signed(y)};
            3'd3: golden = {31'b0, a < y};
            3'd4: golden = a ^ y;
            3'd5: golden = w.r.funct7[5] ? sa >>> y[4:0] : $signed(a >> y[4:0]);
            3'd6: golden = a | y;
            default: golden = a & y;
        endcase
        if (w.u.opcode == core_pkg::opc_lui) begin
            golden = {w.u.imm20, 12'b0};
        end else if (w.u.opcode == core_pkg::opc_auipc) begin
            golden = p + {w.u.imm20, 12'b0};
        end
    endfunction

    // held word reads what the execute instruction writes
    function automatic logic reads_dest(input core_pkg::inst_word held,
                                        input core_pkg::inst_word ex);
        logic r_op, i_op;
        r_op = held.r.opcode == core_pkg::opc_op;
        i_op = held.r.opcode == core_pkg::opc_op_imm;
        return ex.u.rd != '0 && ((r_op || i_op) && held.r.rs1 == ex.u.rd ||
                                 r_op && held.r.rs2 == ex.u.rd);
    endfunction

    assign ret_w       = retire_inst;
    assign expect_data = golden(retire_inst, model[ret_w.r.rs1], model[ret_w.r.rs2], retire_pc);
    assign exe_hazard  = acc_q[0] && reads_dest(inst, inst_q[0]);

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_q <= '0;
            for (int i = 0; i < 32; i++) begin
                model[i] <= '0;
            end
        end else begin
            acc_q <= {acc_q[1:0], inst_valid && !stall && kept(inst)};
            if (retire_valid && ret_w.u.rd != '0) begin
                model[ret_w.u.rd] <= expect_data;
            end
        end
        pc_q   <= '{pc, pc_q[0], pc_q[1]};
        inst_q <= '{inst, inst_q[0], inst_q[1]};
    end

    assert property (@(posedge clk) disable iff (rst) retire_valid |-> retire_data == expect_data)
        else begin
            errors++;
            $error("error %0t retire_data got %h expected %h", $time,
                   $sampled(retire_data), $sampled(expect_data));
        end

    assert property (@(posedge clk) disable iff (rst) retire_valid == acc_q[2])
        else begin
            errors++;
            $error("error %0t retire_valid got %b expected %b", $time,
                   $sampled(retire_valid), $sampled(acc_q[2]));
        end

    assert property (@(posedge clk) disable iff (rst) retire_valid |-> retire_pc == pc_q[2])
        else begin
            errors++;
            $error("error %0t retire_pc got %h expected %h", $time,
                   $sampled(retire_pc), $sampled(pc_q[2]));
        end

    assert property (@(posedge clk) disable iff (rst) retire_valid |-> retire_inst == inst_q[2])
        else begin
            errors++;
            $error("error %0t retire_inst got %h expected %h", $time,
                   $sampled(retire_inst), $sampled(inst_q[2]));
        end

    assert property (@(posedge clk) disable iff (rst) stall == (inst_valid && exe_hazard))
        else begin
            errors++;
            $error("error %0t stall got %b expected %b", $time,
                   $sampled(stall), $sampled(inst_valid && exe_hazard));
        end

    // no write for bubbles or rd x0
    assert property (@(posedge clk) disable iff (rst)
                     retire_wen == (retire_valid && ret_w.u.rd != '0))
        else begin
            errors++;
            $error("error %0t retire_wen got %b expected %b", $time,
                   $sampled(retire_wen), $sampled(retire_valid && ret_w.u.rd != '0));
        end

    assert property (@(posedge clk) disable iff (rst) retire_wen |-> retire_addr == ret_w.u.rd)
        else begin
            errors++;
            $error("error %0t retire_addr got %0d expected %0d", $time,
                   $sampled(retire_addr), $sampled(ret_w.u.rd));
        end

    assert property (@(posedge clk) $past(rst) |-> !retire_valid && !stall)
        else begin
            errors++;
            $error("error %0t retire_valid got %b stall got %b expected both low after reset",
                   $time, $sampled(retire_valid), $sampled(stall));
        end

endmodule

// ==== verification/int_pipeline_tb.sv ====
module int_pipeline_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                            clk = 1'b0;
    logic                            rst, inst_valid, stall, retire_valid, retire_wen;
    logic [core_pkg::xlen-1:0]       inst, pc, retire_pc, retire_inst, retire_data;
    logic [core_pkg::reg_addr_w-1:0] retire_addr;
    logic [31:0]                     lfsr = 32'h9c8aee91;
    int                              accepted = 0;

    // dependent pairs, sub and srai on forwarded values, x0 write and read, lui and auipc
    localparam logic [31:0] directed [10] = '{
        32'h12300093, 32'h00108133, 32'h401101B3, 32'h4031D213, 32'h00500013,
        32'h004062B3, 32'hFFFFF337, 32'h00001397, 32'h007330B3, 32'h00732133
    };

    int_pipeline int_pipeline_inst (.*);

    bind int_pipeline int_pipeline_assertions checks (.*);

    always #2 clk = ~clk;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic give_up(input string what);
        $display("Errors found");
        $fatal(1, "timeout: %s", what);
    endtask

    // registers x0 to x7 only, so hazards come often
    task automatic make_inst(output logic [31:0] w);
        logic [31:0] kind, f3, alt, rd, rs1, rs2, imm;
        logic [6:0]  f7;
        take_bits(3, kind);
        take_bits(3, f3);
        take_bits(1, alt);
        take_bits(3, rd);
        take_bits(3, rs1);
        take_bits(3, rs2);
        take_bits(20, imm);
        f7 = {1'b0, alt[0] && (f3[2:0] == 3'd0 || f3[2:0] == 3'd5), 5'b0};
        case (kind[2:0])
            3'd0, 3'd1, 3'd2: w = {f7, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], core_pkg::opc_op};
            3'd3, 3'd4: begin
                // shifts carry a clean funct7 above shamt
                if (f3[1:0] == 2'b01) begin
                    imm[11:5] = f7;
                end
                w = {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], core_pkg::opc_op_imm};
            end
            3'd5: w = {imm[19:0], rd[4:0], core_pkg::opc_lui};
            3'd6: w = {imm[19:0], rd[4:0], core_pkg::opc_auipc};
            default: w = {imm[19:0], rd[4:0], 7'b1100011};
        endcase
    endtask

    // hold the word until an edge with stall low takes it
    task automatic issue(input logic [31:0] w);
        int waited;
        waited = 0;
        inst_valid = 1'b1;
        inst = w;
        #1;
        while (stall) begin
            @(negedge clk);
            #1;
            waited++;
            if (waited > 4) begin
                give_up("stall stayed high for more than four cycles");
            end
        end
        @(negedge clk);
        pc = pc + 32'd4;
        accepted++;
    endtask

    always @(negedge clk) begin
        if (int_pipeline_inst.checks.errors != 0) begin
            $display("Errors found");
            $fatal(1, "a checker assertion failed");
        end
    end

    initial begin
        logic [31:0] w, r;
        int          quiet, waited;
        rst = 1'b1;
        inst_valid = 1'b0;
        inst = '0;
        pc = 32'h0000_1000;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (directed[k]) begin
            issue(directed[k]);
        end
        while (accepted < 400) begin
            take_bits(3, r);
            if (r[2:0] == 3'd0) begin
                inst_valid = 1'b0;
                @(negedge clk);
            end
            make_inst(w);
            issue(w);
        end
        inst_valid = 1'b0;
        quiet = 0;
        waited = 0;
        while (quiet < 4) begin
            @(negedge clk);
            quiet = retire_valid ? 0 : quiet + 1;
            waited++;
            if (waited > 50) begin
                give_up("retire_valid did not go quiet after the last instruction");
            end
        end
        if (int_pipeline_inst.checks.errors == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1, "checker reported failures");
        end
    end

endmodule
